//--- vlog.f
+incdir+.
id_pkg.sv
id_decoder.sv
id_operand_fwd.sv
id_branch_unit.sv
id_issue_credit.sv
id_stage.sv
id_stage_asserts.sv
tb_id_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "id_settings.svh"

module tb_id_stage;
    import id_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int TEST_CYCLES    = 12 + 6 + 6 + 4 + 40;   // rough length of tests 1 to 5
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    logic       clk = 1'b0;
    logic       rst_n_i;
    logic       inst_valid_i;
    word_t      pc_i;
    word_t      inst_i;
    logic       in_delayslot_i;
    word_t      reg1_data_i;
    word_t      reg2_data_i;
    fwd_src_t   ex_fwd_i;
    fwd_src_t   mem_fwd_i;
    logic       credit_return_i;
    rf_req_t    rf_req_o;
    logic       stall_o;
    branch_t    branch_o;
    logic       dec_valid_o;
    id_packet_t id_packet_o;

    word_t rf_mem [32];          // register file model
    int    seed = 32'hda116066;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    test_err0 = 0;
    int    cycles = 0;
    int    accepted = 0;
    int    issued = 0;
    int    model_credits = `ID_CREDITS;
    branch_t br;

    always #2 clk = ~clk;

    assign reg1_data_i = rf_mem[rf_req_o.reg1_addr];
    assign reg2_data_i = rf_mem[rf_req_o.reg2_addr];

    id_stage DUT
    (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid_i),
        .pc_i            (pc_i),
        .inst_i          (inst_i),
        .in_delayslot_i  (in_delayslot_i),
        .reg1_data_i     (reg1_data_i),
        .reg2_data_i     (reg2_data_i),
        .ex_fwd_i        (ex_fwd_i),
        .mem_fwd_i       (mem_fwd_i),
        .credit_return_i (credit_return_i),
        .rf_req_o        (rf_req_o),
        .stall_o         (stall_o),
        .branch_o        (branch_o),
        .dec_valid_o     (dec_valid_o),
        .id_packet_o     (id_packet_o)
    );

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic word_t enc_r(input int rs, input int rt, input int rd, input int sa,
                                    input logic [5:0] fn);
        return {`ID_OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_ctrl(input alu_op_t op, input alu_sel_t sel, input int wd,
                                input logic wreg);
        check_val("id_packet_o.ctrl.aluop", word_t'(id_packet_o.ctrl.aluop), word_t'(op));
        check_val("id_packet_o.ctrl.alusel", word_t'(id_packet_o.ctrl.alusel), word_t'(sel));
        check_val("id_packet_o.ctrl.wd", word_t'(id_packet_o.ctrl.wd), word_t'(wd));
        check_val("id_packet_o.ctrl.wreg", word_t'(id_packet_o.ctrl.wreg), word_t'(wreg));
        check_val("id_packet_o.ctrl.inst_valid", word_t'(id_packet_o.ctrl.inst_valid), 32'd1);
    endtask

    // drives one instruction until accepted and samples the branch then
    task automatic send(input word_t inst, input word_t pc, input logic ret,
                        output branch_t br_seen);
        @(negedge clk);
        inst_valid_i    = 1'b1;
        inst_i          = inst;
        pc_i            = pc;
        credit_return_i = 1'b0;
        #1;
        while (stall_o)
        begin
            @(negedge clk);
            #1;
        end
        br_seen = branch_o;
        @(negedge clk);
        inst_valid_i    = 1'b0;
        credit_return_i = ret;
        check_val("dec_valid_o", word_t'(dec_valid_o), 32'd1);
        check_val("id_packet_o.inst", id_packet_o.inst, inst);
        check_val("id_packet_o.in_delayslot", word_t'(id_packet_o.in_delayslot),
                  word_t'(in_delayslot_i));
    endtask

    task automatic clear_fwd();
        ex_fwd_i  = '0;
        mem_fwd_i = '0;
    endtask

    task automatic test_end(input string name);
        tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == test_err0) ? "ok" : "failed", errors - test_err0);
        test_err0 = errors;
    endtask

    ////////////////////
    // scoreboard side
    ////////////////////
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("Finished with errors");
            $finish;
        end
        else if (!rst_n_i)
        begin
            model_credits <= `ID_CREDITS;
        end
        else
        begin
            if (inst_valid_i && !stall_o)
                accepted <= accepted + 1;
            if (dec_valid_o)
                issued <= issued + 1;
            model_credits <= model_credits - int'(inst_valid_i && !stall_o)
                             + int'(credit_return_i);
        end
    end

    always @(negedge clk)
    begin
        if (rst_n_i)
            check_val("stall_o", word_t'(stall_o), word_t'(model_credits == 0));
    end

    initial
    begin
        rst_n_i         = 1'b0;
        inst_valid_i    = 1'b0;
        pc_i            = '0;
        inst_i          = '0;
        in_delayslot_i  = 1'b0;
        credit_return_i = 1'b0;
        clear_fwd();
        for (int i = 0; i < 32; i++)
            rf_mem[i] = $random(seed);
        rf_mem[2] = rf_mem[2] | 32'h1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        check_val("dec_valid_o", word_t'(dec_valid_o), 32'd0);
        check_val("branch_o.flag", word_t'(branch_o.flag), 32'd0);
        check_val("stall_o", word_t'(stall_o), 32'd0);
        test_end("reset");

        send(enc_i(`ID_OP_ORI, 3, 7, 16'h8123), 32'h100, 1'b1, br);
        compare_ctrl(ALU_OR, SEL_LOGIC, 7, 1'b1);
        check_val("id_packet_o.reg1", id_packet_o.reg1, rf_mem[3]);
        check_val("id_packet_o.reg2", id_packet_o.reg2, 32'h0000_8123);
        send(enc_i(`ID_OP_ANDI, 4, 8, 16'hf00f), 32'h104, 1'b1, br);
        compare_ctrl(ALU_AND, SEL_LOGIC, 8, 1'b1);
        check_val("id_packet_o.reg2", id_packet_o.reg2, 32'h0000_f00f);
        send(enc_i(`ID_OP_XORI, 5, 9, 16'h8001), 32'h108, 1'b1, br);
        compare_ctrl(ALU_XOR, SEL_LOGIC, 9, 1'b1);
        check_val("id_packet_o.reg2", id_packet_o.reg2, 32'h0000_8001);
        send(enc_i(`ID_OP_ADDI, 6, 10, 16'h8123), 32'h10c, 1'b1, br);
        compare_ctrl(ALU_ADDI, SEL_ARITH, 10, 1'b1);
        check_val("id_packet_o.reg2", id_packet_o.reg2, 32'hffff_8123);
        send(enc_i(`ID_OP_SLTI, 6, 11, 16'hfff0), 32'h110, 1'b1, br);
        compare_ctrl(ALU_SLT, SEL_ARITH, 11, 1'b1);
        check_val("id_packet_o.reg2", id_packet_o.reg2, 32'hffff_fff0);
        send(enc_r(0, 5, 9, 7, `ID_FN_SLL), 32'h114, 1'b1, br);
        compare_ctrl(ALU_SLL, SEL_SHIFT, 9, 1'b1);
        check_val("id_packet_o.reg1", id_packet_o.reg1, 32'd7);
        check_val("id_packet_o.reg2", id_packet_o.reg2, rf_mem[5]);
        test_end("decode");

        // execute and memory both write r4
        ex_fwd_i  = '{wreg: 1'b1, wd: 5'd4, wdata: 32'haaaa_0001};
        mem_fwd_i = '{wreg: 1'b1, wd: 5'd4, wdata: 32'hbbbb_0002};
        send(enc_r(4, 6, 12, 0, `ID_FN_ADD), 32'h200, 1'b1, br);
        compare_ctrl(ALU_ADD, SEL_ARITH, 12, 1'b1);
        check_val("id_packet_o.reg1", id_packet_o.reg1, 32'haaaa_0001);
        check_val("id_packet_o.reg2", id_packet_o.reg2, rf_mem[6]);
        ex_fwd_i.wd = 5'd10;
        send(enc_r(4, 6, 12, 0, `ID_FN_ADD), 32'h204, 1'b1, br);
        check_val("id_packet_o.reg1", id_packet_o.reg1, 32'hbbbb_0002);
        clear_fwd();
        send(enc_r(4, 6, 12, 0, `ID_FN_ADD), 32'h208, 1'b1, br);
        check_val("id_packet_o.reg1", id_packet_o.reg1, rf_mem[4]);
        test_end("forwarding");

        send(enc_i(`ID_OP_BEQ, 2, 2, 16'h0010), 32'h300, 1'b1, br);
        check_val("branch_o.flag", word_t'(br.flag), 32'd1);
        check_val("branch_o.target", br.target, 32'h304 + 32'h40);
        ex_fwd_i       = '{wreg: 1'b1, wd: 5'd8, wdata: 32'h0000_1234};
        in_delayslot_i = 1'b1;                    // sits in the beq delay slot
        send(enc_i(`ID_OP_REGIMM, 8, 1, 16'hfffc), 32'h320, 1'b1, br);
        check_val("branch_o.flag", word_t'(br.flag), 32'd1);
        check_val("branch_o.target", br.target, 32'h324 - 32'h10);
        in_delayslot_i = 1'b0;
        clear_fwd();
        send(enc_i(`ID_OP_BNE, 2, 2, 16'h0010), 32'h340, 1'b1, br);
        check_val("branch_o.flag", word_t'(br.flag), 32'd0);
        test_end("branches");

        send({`ID_OP_JAL, 26'h012_3456}, 32'h4000_1000, 1'b1, br);
        check_val("branch_o.flag", word_t'(br.flag), 32'd1);
        check_val("branch_o.target", br.target, {4'h4, 26'h012_3456, 2'b00});
        check_val("id_packet_o.link_addr", id_packet_o.link_addr, 32'h4000_1008);
        check_val("id_packet_o.ctrl.wd", word_t'(id_packet_o.ctrl.wd), 32'd31);
        send(enc_r(12, 0, 0, 0, `ID_FN_JR), 32'h500, 1'b1, br);
        check_val("branch_o.flag", word_t'(br.flag), 32'd1);
        check_val("branch_o.target", br.target, rf_mem[12]);
        test_end("jumps");

        for (int i = 0; i < `ID_CREDITS; i++)
            send(enc_i(`ID_OP_ORI, 1, 2, 16'(i)), 32'h600 + 4 * i, 1'b0, br);
        check_val("stall_o", word_t'(stall_o), 32'd1);
        inst_valid_i = 1'b1;                      // taken beq held while stalled
        inst_i       = enc_i(`ID_OP_BEQ, 2, 2, 16'h0004);
        pc_i         = 32'h700;
        repeat (3)
        begin
            #1;
            check_val("branch_o.flag", word_t'(branch_o.flag), 32'd0);
            @(negedge clk);
            check_val("dec_valid_o", word_t'(dec_valid_o), 32'd0);
        end
        credit_return_i = 1'b1;
        @(negedge clk);
        credit_return_i = 1'b0;
        #1;
        check_val("branch_o.flag", word_t'(branch_o.flag), 32'd1);
        @(negedge clk);
        inst_valid_i = 1'b0;
        check_val("dec_valid_o", word_t'(dec_valid_o), 32'd1);
        credit_return_i = 1'b1;
        repeat (`ID_CREDITS) @(negedge clk);
        credit_return_i = 1'b0;
        for (int i = 0; i < `ID_CREDITS - 1; i++)
            send(enc_i(`ID_OP_ORI, 1, 2, 16'(i)), 32'h800 + 4 * i, 1'b0, br);
        inst_valid_i    = 1'b1;                   // last credit spent and returned at once
        credit_return_i = 1'b1;
        @(negedge clk);
        inst_valid_i    = 1'b0;
        check_val("stall_o", word_t'(stall_o), 32'd0);
        repeat (`ID_CREDITS - 1) @(negedge clk);
        credit_return_i = 1'b0;
        repeat (3) @(negedge clk);
        check_val("issued", word_t'(issued), word_t'(accepted));
        test_end("credits");

        errors = errors + int'(DUT.u_chk.fail_cnt);
        $display("tests %0d, checks %0d, accepted %0d, issued %0d, errors %0d",
                 tests, checks, accepted, issued, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- id_stage_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage_asserts
(
    input logic            clk,
    input logic            rst_n_i,
    input logic            inst_valid_i,
    input logic            credit_return_i,
    input logic            stall_o,
    input logic            dec_valid_o,
    input id_pkg::branch_t branch_o
);

    int unsigned fail_cnt = 0;   // read by the testbench at the end
    logic        accept;

    assign accept = inst_valid_i && !stall_o;

    ////////////////////
    // issue timing
    ////////////////////
    a_issue_next: assert property (@(posedge clk) disable iff (!rst_n_i)
        accept |=> dec_valid_o)
    else
    begin
        fail_cnt++;
        $error("dec_valid_o missing one cycle after an accepted instruction");
    end

    a_no_extra_issue: assert property (@(posedge clk) disable iff (!rst_n_i)
        !accept |=> !dec_valid_o)
    else
    begin
        fail_cnt++;
        $error("dec_valid_o raised without an accepted instruction");
    end

    // redirect only for accepted work
    a_stall_no_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |-> !branch_o.flag)
    else
    begin
        fail_cnt++;
        $error("branch flag raised while stalled");
    end

    a_delay_slot: assert property (@(posedge clk) disable iff (!rst_n_i)
        branch_o.flag == branch_o.next_in_delayslot)
    else
    begin
        fail_cnt++;
        $error("delay-slot flag does not follow the branch flag");
    end

    a_return_keeps: assert property (@(posedge clk) disable iff (!rst_n_i)
        (accept && credit_return_i) |=> !stall_o)
    else
    begin
        fail_cnt++;
        $error("issue with a returned credit raised stall");
    end

    ////////////////////
    // reset state
    ////////////////////
    a_reset_state: assert property (@(posedge clk)
        !rst_n_i |=> (!dec_valid_o && !stall_o))
    else
    begin
        fail_cnt++;
        $error("dec_valid_o or stall_o set after reset");
    end

endmodule

bind id_stage id_stage_asserts u_chk
(
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .inst_valid_i    (inst_valid_i),
    .credit_return_i (credit_return_i),
    .stall_o         (stall_o),
    .dec_valid_o     (dec_valid_o),
    .branch_o        (branch_o)
);

`default_nettype wire

//--- id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  id_pkg::word_t      pc_i,
    input  id_pkg::word_t      inst_i,
    input  logic               in_delayslot_i,
    input  id_pkg::word_t      reg1_data_i,
    input  id_pkg::word_t      reg2_data_i,
    input  id_pkg::fwd_src_t   ex_fwd_i,
    input  id_pkg::fwd_src_t   mem_fwd_i,
    input  logic               credit_return_i,
    output id_pkg::rf_req_t    rf_req_o,
    output logic               stall_o,
    output id_pkg::branch_t    branch_o,
    output logic               dec_valid_o,
    output id_pkg::id_packet_t id_packet_o
);
    import id_pkg::*;

    dec_ctrl_t  ctrl;
    word_t      imm;
    word_t      reg1;
    word_t      reg2;
    word_t      link_addr;
    id_packet_t packet;
    logic       accept;

    assign accept = inst_valid_i && !stall_o;

    id_decoder u_decoder
    (
        .inst_i   (inst_i),
        .rf_req_o (rf_req_o),
        .ctrl_o   (ctrl),
        .imm_o    (imm)
    );

    ////////////////////
    // operands
    ////////////////////
    id_operand_fwd op1_sel
    (
        .read_i    (rf_req_o.reg1_read),
        .addr_i    (rf_req_o.reg1_addr),
        .rf_data_i (reg1_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg1)
    );

    id_operand_fwd op2_sel
    (
        .read_i    (rf_req_o.reg2_read),
        .addr_i    (rf_req_o.reg2_addr),
        .rf_data_i (reg2_data_i),
        .imm_i     (imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (reg2)
    );

    id_branch_unit u_branch
    (
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .ctrl_i      (ctrl),
        .reg1_i      (reg1),
        .reg2_i      (reg2),
        .accept_i    (accept),
        .branch_o    (branch_o),
        .link_addr_o (link_addr)
    );

    assign packet = '{
        ctrl:         ctrl,
        reg1:         reg1,
        reg2:         reg2,
        link_addr:    link_addr,
        inst:         inst_i,
        in_delayslot: in_delayslot_i
    };

    id_issue_credit u_issue
    (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .inst_valid_i    (inst_valid_i),
        .credit_return_i (credit_return_i),
        .packet_i        (packet),
        .stall_o         (stall_o),
        .dec_valid_o     (dec_valid_o),
        .packet_o        (id_packet_o)
    );

endmodule

`default_nettype wire

//--- id_issue_credit.sv
`timescale 1ns/10ps
`default_nettype none
`include "id_settings.svh"

module id_issue_credit
(
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,
    input  logic               credit_return_i,
    input  id_pkg::id_packet_t packet_i,
    output logic               stall_o,
    output logic               dec_valid_o,
    output id_pkg::id_packet_t packet_o
);

    localparam int CNT_W = $clog2(`ID_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`ID_CREDITS);

    logic [CNT_W-1:0] credits;     // free slots downstream
    logic             issue;

    assign stall_o = (credits == '0);
    assign issue   = inst_valid_i && !stall_o;

    ////////////////////
    // credit counter
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            credits     <= CNT_MAX;
            dec_valid_o <= 1'b0;
        end
        else
        begin
            dec_valid_o <= issue;
            case ({issue, credit_return_i})
                2'b10:
                begin
                    credits <= credits - 1'b1;
                end
                2'b01:
                begin
                    if (credits != CNT_MAX)  // ignore a stray return
                        credits <= credits + 1'b1;
                end
                default:
                begin
                    credits <= credits;      // both or neither
                end
            endcase
        end
    end

    // issue slot payload
    always_ff @(posedge clk)
    begin
        if (issue)
            packet_o <= packet_i;
    end

endmodule

`default_nettype wire

//--- id_branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module id_branch_unit
(
    input  id_pkg::word_t     pc_i,
    input  id_pkg::word_t     inst_i,
    input  id_pkg::dec_ctrl_t ctrl_i,
    input  id_pkg::word_t     reg1_i,
    input  id_pkg::word_t     reg2_i,
    input  logic              accept_i,
    output id_pkg::branch_t   branch_o,
    output id_pkg::word_t     link_addr_o
);
    import id_pkg::*;

    word_t pc_plus_4;
    word_t pc_plus_8;
    word_t br_target;
    word_t jmp_target;
    word_t target;
    logic  taken;
    logic  fire;

    assign pc_plus_4  = pc_i + 4;
    assign pc_plus_8  = pc_i + 8;   // skips the delay slot
    assign br_target  = pc_plus_4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jmp_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

    ////////////////////
    // condition
    ////////////////////
    always_comb
    begin
        taken  = 1'b0;
        target = br_target;
        case (ctrl_i.aluop)
            ALU_J, ALU_JAL:
            begin
                taken  = 1'b1;
                target = jmp_target;
            end
            ALU_JR, ALU_JALR:
            begin
                taken  = 1'b1;
                target = reg1_i;
            end
            ALU_BEQ:              taken = (reg1_i == reg2_i);
            ALU_BNE:              taken = (reg1_i != reg2_i);
            ALU_BGTZ:             taken = !reg1_i[31] && (reg1_i != '0);
            ALU_BLEZ:             taken = reg1_i[31] || (reg1_i == '0);
            ALU_BGEZ, ALU_BGEZAL: taken = !reg1_i[31];
            ALU_BLTZ, ALU_BLTZAL: taken = reg1_i[31];
            default:              taken = 1'b0;
        endcase
    end

    assign fire = taken && accept_i;     // nothing redirects while stalled

    always_comb
    begin
        branch_o.flag              = fire;
        branch_o.target            = fire ? target : '0;
        branch_o.next_in_delayslot = fire;
    end

    // linking forms write pc+8 whether taken or not
    assign link_addr_o = (ctrl_i.wreg && (ctrl_i.alusel == SEL_JUMP_BRANCH)) ? pc_plus_8 : '0;

endmodule

`default_nettype wire

//--- id_operand_fwd.sv
`timescale 1ns/10ps
`default_nettype none

module id_operand_fwd
(
    input  logic              read_i,
    input  id_pkg::reg_addr_t addr_i,
    input  id_pkg::word_t     rf_data_i,
    input  id_pkg::word_t     imm_i,
    input  id_pkg::fwd_src_t  ex_fwd_i,
    input  id_pkg::fwd_src_t  mem_fwd_i,
    output id_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // raw hazards against instructions still in flight
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb
    begin
        if (!read_i)
        begin
            operand_o = imm_i;
        end
        else if (ex_hit)            // youngest producer wins
        begin
            operand_o = ex_fwd_i.wdata;
        end
        else if (mem_hit)
        begin
            operand_o = mem_fwd_i.wdata;
        end
        else
        begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

//--- id_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "id_settings.svh"

module id_decoder
(
    input  id_pkg::word_t     inst_i,
    output id_pkg::rf_req_t   rf_req_o,
    output id_pkg::dec_ctrl_t ctrl_o,
    output id_pkg::word_t     imm_o
);
    import id_pkg::*;

    logic [5:0]  op;
    logic [5:0]  funct;
    logic [15:0] imm16;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   sa;
    logic        shift_imm;
    logic        i_alu;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    assign shift_imm = (funct == `ID_FN_SLL) || (funct == `ID_FN_SRL) || (funct == `ID_FN_SRA);
    assign i_alu     = (op[5:3] == 3'b001);  // addi .. lui

    function automatic alu_op_t special_op(input logic [5:0] fn);
        case (fn)
            `ID_FN_OR:   return ALU_OR;
            `ID_FN_AND:  return ALU_AND;
            `ID_FN_XOR:  return ALU_XOR;
            `ID_FN_NOR:  return ALU_NOR;
            `ID_FN_SLL,
            `ID_FN_SLLV: return ALU_SLL;
            `ID_FN_SRL,
            `ID_FN_SRLV: return ALU_SRL;
            `ID_FN_SRA,
            `ID_FN_SRAV: return ALU_SRA;
            `ID_FN_ADD:  return ALU_ADD;
            `ID_FN_ADDU: return ALU_ADDU;
            `ID_FN_SUB:  return ALU_SUB;
            `ID_FN_SUBU: return ALU_SUBU;
            `ID_FN_SLT:  return ALU_SLT;
            `ID_FN_SLTU: return ALU_SLTU;
            `ID_FN_JR:   return ALU_JR;
            `ID_FN_JALR: return ALU_JALR;
            default:     return ALU_NOP;
        endcase
    endfunction

    function automatic alu_sel_t op_class(input alu_op_t aop);
        case (aop)
            ALU_NOP:                           return SEL_NOP;
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: return SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         return SEL_SHIFT;
            ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
            ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
            ALU_BGEZ, ALU_BGEZAL, ALU_BLTZ, ALU_BLTZAL:
                                               return SEL_JUMP_BRANCH;
            default:                           return SEL_ARITH;
        endcase
    endfunction

    ////////////////////
    // control decode
    ////////////////////
    always_comb
    begin
        ctrl_o.aluop       = ALU_NOP;
        ctrl_o.wd          = rt;         // i-type target
        ctrl_o.wreg        = 1'b0;
        rf_req_o.reg1_read = 1'b0;
        rf_req_o.reg2_read = 1'b0;
        rf_req_o.reg1_addr = rs;
        rf_req_o.reg2_addr = rt;
        case (op)
            `ID_OP_SPECIAL:
            begin
                ctrl_o.aluop = special_op(funct);
                ctrl_o.wd    = rd;
                ctrl_o.wreg  = (ctrl_o.aluop != ALU_JR);
                if (shift_imm)
                begin
                    rf_req_o.reg2_read = 1'b1;   // shift amount comes in on reg1
                    if (rs != '0)
                        ctrl_o.aluop = ALU_NOP;
                end
                else
                begin
                    rf_req_o.reg1_read = 1'b1;
                    rf_req_o.reg2_read = (ctrl_o.aluop != ALU_JR) && (ctrl_o.aluop != ALU_JALR);
                    if (sa != '0)
                        ctrl_o.aluop = ALU_NOP;
                end
            end
            `ID_OP_REGIMM:
            begin
                rf_req_o.reg1_read = 1'b1;
                ctrl_o.wreg        = rt[4];      // the al forms link
                ctrl_o.wd          = `ID_LINK_REG;
                case (rt)
                    `ID_RI_BLTZ:   ctrl_o.aluop = ALU_BLTZ;
                    `ID_RI_BGEZ:   ctrl_o.aluop = ALU_BGEZ;
                    `ID_RI_BLTZAL: ctrl_o.aluop = ALU_BLTZAL;
                    `ID_RI_BGEZAL: ctrl_o.aluop = ALU_BGEZAL;
                    default:       ctrl_o.aluop = ALU_NOP;
                endcase
            end
            `ID_OP_ORI, `ID_OP_LUI: ctrl_o.aluop = ALU_OR;
            `ID_OP_ANDI:            ctrl_o.aluop = ALU_AND;
            `ID_OP_XORI:            ctrl_o.aluop = ALU_XOR;
            `ID_OP_ADDI:            ctrl_o.aluop = ALU_ADDI;
            `ID_OP_ADDIU:           ctrl_o.aluop = ALU_ADDIU;
            `ID_OP_SLTI:            ctrl_o.aluop = ALU_SLT;
            `ID_OP_SLTIU:           ctrl_o.aluop = ALU_SLTU;
            `ID_OP_J:               ctrl_o.aluop = ALU_J;
            `ID_OP_JAL:
            begin
                ctrl_o.aluop = ALU_JAL;
                ctrl_o.wreg  = 1'b1;
                ctrl_o.wd    = `ID_LINK_REG;
            end
            `ID_OP_BEQ:             ctrl_o.aluop = ALU_BEQ;
            `ID_OP_BNE:             ctrl_o.aluop = ALU_BNE;
            `ID_OP_BLEZ:            ctrl_o.aluop = ALU_BLEZ;
            `ID_OP_BGTZ:            ctrl_o.aluop = ALU_BGTZ;
            default:                ctrl_o.aluop = ALU_NOP;
        endcase

        if (i_alu)
        begin
            ctrl_o.wreg        = 1'b1;
            rf_req_o.reg1_read = 1'b1;
        end
        if (op[5:2] == 4'b0001)                 // beq, bne, blez, bgtz
        begin
            rf_req_o.reg1_read = 1'b1;
            rf_req_o.reg2_read = !op[1];
        end

        // anything left at nop is an encoding we do not handle
        ctrl_o.inst_valid = (ctrl_o.aluop != ALU_NOP);
        if (!ctrl_o.inst_valid)
        begin
            ctrl_o.wreg        = 1'b0;
            rf_req_o.reg1_read = 1'b0;
            rf_req_o.reg2_read = 1'b0;
        end
        ctrl_o.alusel = op_class(ctrl_o.aluop);
    end

    // immediate forms
    always_comb
    begin
        case (op)
            `ID_OP_SPECIAL:                       imm_o = word_t'(sa);
            `ID_OP_ORI, `ID_OP_ANDI, `ID_OP_XORI: imm_o = {16'h0, imm16};
            `ID_OP_LUI:                           imm_o = {imm16, 16'h0};
            `ID_OP_ADDI, `ID_OP_ADDIU,
            `ID_OP_SLTI, `ID_OP_SLTIU:            imm_o = {{16{imm16[15]}}, imm16};
            default:                              imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- id_pkg.sv
`default_nettype none
`include "id_settings.svh"

package id_pkg;

    typedef logic [`ID_WORD_W-1:0]     word_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [7:0] {
        ALU_NOP    = 8'b00000000,
        ALU_AND    = 8'b00100100,
        ALU_OR     = 8'b00100101,
        ALU_XOR    = 8'b00100110,
        ALU_NOR    = 8'b00100111,
        ALU_SLL    = 8'b01111100,
        ALU_SRL    = 8'b00000010,
        ALU_SRA    = 8'b00000011,
        ALU_SLT    = 8'b00101010,
        ALU_SLTU   = 8'b00101011,
        ALU_ADD    = 8'b00100000,
        ALU_ADDU   = 8'b00100001,
        ALU_SUB    = 8'b00100010,
        ALU_SUBU   = 8'b00100011,
        ALU_ADDI   = 8'b01010101,
        ALU_ADDIU  = 8'b01010110,
        ALU_J      = 8'b01001111,
        ALU_JAL    = 8'b01010000,
        ALU_JR     = 8'b00001000,
        ALU_JALR   = 8'b00001001,
        ALU_BEQ    = 8'b01010001,
        ALU_BNE    = 8'b01010010,
        ALU_BGTZ   = 8'b01010100,
        ALU_BLEZ   = 8'b01010011,
        ALU_BGEZ   = 8'b01000001,
        ALU_BGEZAL = 8'b01001011,
        ALU_BLTZ   = 8'b01000000,
        ALU_BLTZAL = 8'b01001010
    } alu_op_t;

    typedef enum logic [2:0] {
        SEL_NOP         = 3'b000,
        SEL_LOGIC       = 3'b001,
        SEL_SHIFT       = 3'b010,
        SEL_ARITH       = 3'b100,
        SEL_JUMP_BRANCH = 3'b110
    } alu_sel_t;

    // write-back seen from execute or memory
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
    } rf_req_t;

    typedef struct packed {
        alu_op_t   aluop;
        alu_sel_t  alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      inst_valid;
    } dec_ctrl_t;

    typedef struct packed {
        dec_ctrl_t ctrl;
        word_t     reg1;
        word_t     reg2;
        word_t     link_addr;
        word_t     inst;
        logic      in_delayslot;
    } id_packet_t;

    typedef struct packed {
        logic  flag;
        word_t target;
        logic  next_in_delayslot;
    } branch_t;

endpackage

`default_nettype wire

//--- id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

`define ID_WORD_W       32
`define ID_REG_ADDR_W   5
`define ID_CREDITS      4      // issue slots held by execute
`define ID_LINK_REG     5'd31

// opcodes
`define ID_OP_SPECIAL   6'b000000
`define ID_OP_REGIMM    6'b000001
`define ID_OP_J         6'b000010
`define ID_OP_JAL       6'b000011
`define ID_OP_BEQ       6'b000100
`define ID_OP_BNE       6'b000101
`define ID_OP_BLEZ      6'b000110
`define ID_OP_BGTZ      6'b000111
`define ID_OP_ADDI      6'b001000
`define ID_OP_ADDIU     6'b001001
`define ID_OP_SLTI      6'b001010
`define ID_OP_SLTIU     6'b001011
`define ID_OP_ANDI      6'b001100
`define ID_OP_ORI       6'b001101
`define ID_OP_XORI      6'b001110
`define ID_OP_LUI       6'b001111

// special function codes
`define ID_FN_SLL       6'b000000
`define ID_FN_SRL       6'b000010
`define ID_FN_SRA       6'b000011
`define ID_FN_SLLV      6'b000100
`define ID_FN_SRLV      6'b000110
`define ID_FN_SRAV      6'b000111
`define ID_FN_JR        6'b001000
`define ID_FN_JALR      6'b001001
`define ID_FN_ADD       6'b100000
`define ID_FN_ADDU      6'b100001
`define ID_FN_SUB       6'b100010
`define ID_FN_SUBU      6'b100011
`define ID_FN_AND       6'b100100
`define ID_FN_OR        6'b100101
`define ID_FN_XOR       6'b100110
`define ID_FN_NOR       6'b100111
`define ID_FN_SLT       6'b101010
`define ID_FN_SLTU      6'b101011

// regimm rt codes
`define ID_RI_BLTZ      5'b00000
`define ID_RI_BGEZ      5'b00001
`define ID_RI_BLTZAL    5'b10000
`define ID_RI_BGEZAL    5'b10001

`endif
